// File: include/ecc_cfg.svh
`ifndef ECC_CFG_SVH
`define ECC_CFG_SVH

// four protected lanes per stored word.
`define ECC_LANES        4
`define ECC_DATA_WIDTH   48
`define ECC_PARITY_WIDTH 7

`define ECC_DEPTH        16
`define ECC_ADDR_WIDTH   4

`endif

// File: source/ecc_code_pkg.sv
`include "ecc_cfg.svh"

package ecc_code_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // single lane
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [`ECC_DATA_WIDTH-1:0]   lane_data_t;
    typedef logic [`ECC_PARITY_WIDTH-1:0] parity_t;

    typedef struct packed {
        lane_data_t data;
        parity_t    parity; // check bits sit below the data.
    } codeword_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // full word as kept in the RAM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef codeword_t [`ECC_LANES-1:0] word_cw_t;

    // a set bit flips the matching bit of the stored word.
    typedef logic [`ECC_LANES*(`ECC_DATA_WIDTH+`ECC_PARITY_WIDTH)-1:0] inject_t;

    typedef enum logic [1:0] {
        err_none,
        err_single, // corrected, or a flipped check bit.
        err_double
    } err_kind_t;

endpackage

// File: source/ecc_txn_pkg.sv
`include "ecc_cfg.svh"

package ecc_txn_pkg;

    import ecc_code_pkg::*;

    typedef enum logic [1:0] {
        op_write,
        op_read,
        op_read_raw // stored data without any correction.
    } opcode_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // port payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        opcode_t                                 opcode;
        logic [`ECC_ADDR_WIDTH-1:0]              addr;
        logic [`ECC_LANES*`ECC_DATA_WIDTH-1:0]   data;
        inject_t                                 inject;
    } mem_req_t;

    typedef struct packed {
        opcode_t                                 opcode;
        logic [`ECC_LANES*`ECC_DATA_WIDTH-1:0]   data;
        logic [`ECC_LANES-1:0]                   sbit;
        logic [`ECC_LANES-1:0]                   dbit;
    } mem_rsp_t;

    // what the response side still needs once the lanes have run.
    typedef struct packed {
        opcode_t                    opcode;
        logic [`ECC_ADDR_WIDTH-1:0] addr;
        inject_t                    inject;
    } stage_t;

endpackage

// File: source/ecc_word_ram.sv
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module ecc_word_ram
    import ecc_code_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       rd_en,
    input  logic [`ECC_ADDR_WIDTH-1:0] rd_addr,
    output word_cw_t                   rd_data,
    input  logic                       wr_en,
    input  logic [`ECC_ADDR_WIDTH-1:0] wr_addr,
    input  word_cw_t                   wr_data
);

    word_cw_t mem [`ECC_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_data;
    end

    // a read that collides with a write sees the new word.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= (wr_en && wr_addr == rd_addr) ? wr_data : mem[rd_addr];
        end
    end

endmodule

// File: source/ecc_secded_lane.sv
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module ecc_secded_lane
    import ecc_code_pkg::*;
(
    input  codeword_t  cw_in,
    input  logic       bypass,
    output codeword_t  cw_out,
    output lane_data_t data_fixed,
    output err_kind_t  err
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // parity check matrix, one column per data bit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // bit k of a column says data bit i feeds parity bit k.
    localparam logic [0:`ECC_DATA_WIDTH-1][`ECC_PARITY_WIDTH-1:0] h_cols = '{
        7'b1000011, 7'b1000101, 7'b1000110, 7'b0000111, 7'b1001001, 7'b1001010,
        7'b0001011, 7'b1001100, 7'b0001101, 7'b0001110, 7'b1001111, 7'b1010001,
        7'b1010010, 7'b0010011, 7'b1010100, 7'b0010101, 7'b0010110, 7'b1010111,
        7'b1011000, 7'b0011001, 7'b0011010, 7'b1011011, 7'b0011100, 7'b1011101,
        7'b1011110, 7'b0011111, 7'b1100001, 7'b1100010, 7'b0100011, 7'b1100100,
        7'b0100101, 7'b0100110, 7'b1100111, 7'b1101000, 7'b0101001, 7'b0101010,
        7'b1101011, 7'b0101100, 7'b1101101, 7'b1101110, 7'b0101111, 7'b1110000,
        7'b0110001, 7'b0110010, 7'b1110011, 7'b0110100, 7'b1110101, 7'b1110110
    };

    parity_t    parity_calc;
    parity_t    syndrome;
    lane_data_t flip;
    err_kind_t  kind;

    // encoder.
    always_comb begin
        parity_calc = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (cw_in.data[i]) parity_calc ^= h_cols[i];
        end
    end

    assign syndrome = cw_in.parity ^ parity_calc;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // syndrome decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        flip = '0;
        kind = err_none;
        if (syndrome == '0) begin
            kind = err_none;
        end else if ($onehot(syndrome)) begin
            kind = err_single; // only a check bit was hit, data is fine.
        end else begin
            kind = err_double;
            for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
                if (syndrome == h_cols[i]) begin
                    flip[i] = 1'b1;
                    kind    = err_single;
                end
            end
        end
    end

    assign cw_out.data   = cw_in.data;
    assign cw_out.parity = parity_calc;

    assign data_fixed = bypass ? cw_in.data : (cw_in.data ^ flip);
    assign err        = bypass ? err_none : kind;

endmodule

// File: source/ecc_req_stage.sv
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module ecc_req_stage
    import ecc_code_pkg::*;
    import ecc_txn_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  mem_req_t                   req,
    output logic                       ram_rd_en,
    output logic [`ECC_ADDR_WIDTH-1:0] ram_rd_addr,
    input  word_cw_t                   ram_rd_data,
    output word_cw_t                   lane_in,
    output logic                       lane_bypass,
    output logic                       stage_valid,
    output stage_t                     stage,
    input  logic                       stage_ready
);

    logic                                  accept;
    logic [`ECC_LANES*`ECC_DATA_WIDTH-1:0] wdata_q;

    assign req_ready = !stage_valid || stage_ready;
    assign accept    = req_valid && req_ready;

    // the read is launched for every request, the RAM output is just ignored on writes.
    assign ram_rd_en   = accept;
    assign ram_rd_addr = req.addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (req_ready) begin
            stage_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage.opcode <= req.opcode;
            stage.addr   <= req.addr;
            stage.inject <= req.inject;
            wdata_q      <= req.data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane input selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // writes reuse the checker as an encoder by feeding zero parity.
    always_comb begin
        for (int l = 0; l < `ECC_LANES; l++) begin
            if (stage.opcode == op_write) begin
                lane_in[l].data   = wdata_q[l*`ECC_DATA_WIDTH +: `ECC_DATA_WIDTH];
                lane_in[l].parity = '0;
            end else begin
                lane_in[l] = ram_rd_data[l];
            end
        end
    end

    assign lane_bypass = (stage.opcode == op_read_raw);

endmodule

// File: source/ecc_rsp_merge.sv
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module ecc_rsp_merge
    import ecc_code_pkg::*;
    import ecc_txn_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  stage_valid,
    output logic                                  stage_ready,
    input  stage_t                                stage,
    input  word_cw_t                              lane_cw,
    input  logic [`ECC_LANES*`ECC_DATA_WIDTH-1:0] lane_fixed,
    input  err_kind_t [`ECC_LANES-1:0]            lane_err,
    output logic                                  ram_wr_en,
    output logic [`ECC_ADDR_WIDTH-1:0]            ram_wr_addr,
    output word_cw_t                              ram_wr_data,
    output logic                                  rsp_valid,
    input  logic                                  rsp_ready,
    output mem_rsp_t                              rsp
);

    logic                  consume;
    logic [`ECC_LANES-1:0] sbit_d;
    logic [`ECC_LANES-1:0] dbit_d;

    assign stage_ready = !rsp_valid || rsp_ready;
    assign consume     = stage_valid && stage_ready;

    // stored word is the fresh encoding, with test flips applied.
    assign ram_wr_en   = consume && (stage.opcode == op_write);
    assign ram_wr_addr = stage.addr;
    assign ram_wr_data = lane_cw ^ stage.inject;

    always_comb begin
        for (int l = 0; l < `ECC_LANES; l++) begin
            sbit_d[l] = (lane_err[l] == err_single);
            dbit_d[l] = (lane_err[l] == err_double);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (stage_ready) begin
            rsp_valid <= stage_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (consume) begin
            rsp.opcode <= stage.opcode;
            case (stage.opcode)
                op_read: begin
                    rsp.data <= lane_fixed;
                    rsp.sbit <= sbit_d;
                    rsp.dbit <= dbit_d;
                end
                op_read_raw: begin
                    rsp.data <= lane_fixed; // lanes are bypassed here.
                    rsp.sbit <= '0;
                    rsp.dbit <= '0;
                end
                default: begin
                    rsp.data <= '0;
                    rsp.sbit <= '0;
                    rsp.dbit <= '0;
                end
            endcase
        end
    end

endmodule

// File: source/ecc_mem_top.sv
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module ecc_mem_top
    import ecc_code_pkg::*;
    import ecc_txn_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     req_valid,
    output logic     req_ready,
    input  mem_req_t req,
    output logic     rsp_valid,
    input  logic     rsp_ready,
    output mem_rsp_t rsp
);

    logic                                  ram_rd_en;
    logic [`ECC_ADDR_WIDTH-1:0]            ram_rd_addr;
    word_cw_t                              ram_rd_data;
    logic                                  ram_wr_en;
    logic [`ECC_ADDR_WIDTH-1:0]            ram_wr_addr;
    word_cw_t                              ram_wr_data;
    word_cw_t                              lane_in;
    logic                                  lane_bypass;
    word_cw_t                              lane_cw;
    logic [`ECC_LANES*`ECC_DATA_WIDTH-1:0] lane_fixed;
    err_kind_t [`ECC_LANES-1:0]            lane_err;
    logic                                  stage_valid;
    logic                                  stage_ready;
    stage_t                                stage;

    ecc_req_stage i_req_stage (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .ram_rd_en(ram_rd_en), .ram_rd_addr(ram_rd_addr), .ram_rd_data(ram_rd_data),
        .lane_in(lane_in), .lane_bypass(lane_bypass),
        .stage_valid(stage_valid), .stage(stage), .stage_ready(stage_ready)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one checker per lane
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar g = 0; g < `ECC_LANES; g++) begin : g_lane
        ecc_secded_lane i_lane (
            .cw_in(lane_in[g]),
            .bypass(lane_bypass),
            .cw_out(lane_cw[g]),
            .data_fixed(lane_fixed[g*`ECC_DATA_WIDTH +: `ECC_DATA_WIDTH]),
            .err(lane_err[g])
        );
    end

    ecc_rsp_merge i_rsp_merge (
        .clk(clk), .reset(reset),
        .stage_valid(stage_valid), .stage_ready(stage_ready), .stage(stage),
        .lane_cw(lane_cw), .lane_fixed(lane_fixed), .lane_err(lane_err),
        .ram_wr_en(ram_wr_en), .ram_wr_addr(ram_wr_addr), .ram_wr_data(ram_wr_data),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp)
    );

    ecc_word_ram i_ram (
        .clk(clk), .reset(reset),
        .rd_en(ram_rd_en), .rd_addr(ram_rd_addr), .rd_data(ram_rd_data),
        .wr_en(ram_wr_en), .wr_addr(ram_wr_addr), .wr_data(ram_wr_data)
    );

endmodule

// File: test/ecc_tb.sv
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module ecc_tb
    import ecc_code_pkg::*;
    import ecc_txn_pkg::*;
();

    localparam int clk_period     = 4;
    localparam int reset_cycles   = 4;
    localparam int cycles_per_txn = 20;

    typedef struct packed {
        logic [7:0]                            test_id;
        opcode_t                               op;
        logic [`ECC_ADDR_WIDTH-1:0]            addr;
        logic [`ECC_LANES*`ECC_DATA_WIDTH-1:0] data;
        inject_t                               inject;
        logic [`ECC_LANES*`ECC_DATA_WIDTH-1:0] exp_data;
        logic [`ECC_LANES-1:0]                 sbit;
        logic [`ECC_LANES-1:0]                 dbit;
    } trace_entry_t;

    logic     clk;
    logic     reset;
    logic     req_valid;
    logic     req_ready;
    mem_req_t req;
    logic     rsp_valid;
    logic     rsp_ready;
    mem_rsp_t rsp;

    trace_entry_t trace[$];
    bit           trace_ready = 1'b0;
    int           error_count = 0;

    ecc_mem_top i_dut (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // trace input
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic load_trace(output bit ok);
        int                                    fd;
        int                                    id_v;
        int                                    op_v;
        logic [`ECC_ADDR_WIDTH-1:0]            addr_v;
        logic [`ECC_LANES*`ECC_DATA_WIDTH-1:0] data_v;
        inject_t                               inject_v;
        logic [`ECC_LANES*`ECC_DATA_WIDTH-1:0] exp_v;
        logic [`ECC_LANES-1:0]                 sbit_v;
        logic [`ECC_LANES-1:0]                 dbit_v;
        string                                 line;
        trace_entry_t                          e;
        ok = 1'b0;
        fd = $fopen("test/ecc_trace.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin // skips blanks and comments.
                    if ($sscanf(line, "%d %d %h %h %h %h %h %h", id_v, op_v, addr_v, data_v,
                                inject_v, exp_v, sbit_v, dbit_v) == 8) begin
                        e.test_id  = id_v[7:0];
                        e.op       = opcode_t'(op_v[1:0]);
                        e.addr     = addr_v;
                        e.data     = data_v;
                        e.inject   = inject_v;
                        e.exp_data = exp_v;
                        e.sbit     = sbit_v;
                        e.dbit     = dbit_v;
                        trace.push_back(e);
                    end else begin
                        $display("trace line could not be parsed: %s", line);
                        ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
            if (trace.size() == 0) ok = 1'b0;
        end
    endtask

    // one request per trace entry, held until the DUT takes it.
    task automatic drive_requests();
        int idx;
        idx = 0;
        while (idx < trace.size()) begin
            @(posedge clk);
            if (!req_valid || req_ready) begin
                req_valid  <= 1'b1;
                req.opcode <= trace[idx].op;
                req.addr   <= trace[idx].addr;
                req.data   <= trace[idx].data;
                req.inject <= trace[idx].inject;
                idx++;
            end
        end
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        req_valid <= 1'b0;
    endtask

    task automatic check_response(input trace_entry_t want);
        assert (rsp.opcode === want.op) else begin
            $display("CHECK FAILED at %0t ns: rsp.opcode expected %0d, actual %0d",
                     $time, want.op, rsp.opcode);
            error_count++;
        end
        assert (rsp.data === want.exp_data) else begin
            $display("CHECK FAILED at %0t ns: rsp.data expected %h, actual %h",
                     $time, want.exp_data, rsp.data);
            error_count++;
        end
        assert (rsp.sbit === want.sbit) else begin
            $display("CHECK FAILED at %0t ns: rsp.sbit expected %b, actual %b",
                     $time, want.sbit, rsp.sbit);
            error_count++;
        end
        assert (rsp.dbit === want.dbit) else begin
            $display("CHECK FAILED at %0t ns: rsp.dbit expected %b, actual %b",
                     $time, want.dbit, rsp.dbit);
            error_count++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // processes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : main
        bit load_ok;
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        load_trace(load_ok);
        if (!load_ok) begin
            $display("trace file test/ecc_trace.txt is missing, empty or malformed");
            $display("Test failed");
            $finish;
        end else begin
            trace_ready = 1'b1;
            repeat (reset_cycles) @(posedge clk);
            reset <= 1'b0;
            drive_requests();
        end
    end

    initial begin : ready_gen
        void'($urandom(50));
        rsp_ready = 1'b0;
        forever begin
            @(posedge clk);
            rsp_ready <= ($urandom % 4) != 0; // roughly one stall cycle in four.
        end
    end

    initial begin : response_check
        int n_done;
        int n_tests;
        int test_rsp;
        int test_err_base;
        bit last_of_test;
        n_done        = 0;
        n_tests       = 0;
        test_rsp      = 0;
        test_err_base = 0;
        wait (trace_ready);
        while (n_done < trace.size()) begin
            @(posedge clk);
            if (rsp_valid && rsp_ready) begin
                check_response(trace[n_done]);
                test_rsp++;
                last_of_test = (n_done == trace.size() - 1);
                if (!last_of_test) begin
                    last_of_test = (trace[n_done + 1].test_id != trace[n_done].test_id);
                end
                if (last_of_test) begin
                    $display("test %0d finished: %0d responses, %0d errors",
                             trace[n_done].test_id, test_rsp, error_count - test_err_base);
                    n_tests++;
                    test_rsp      = 0;
                    test_err_base = error_count;
                end
                n_done++;
            end
        end
        repeat (4) @(posedge clk);
        assert (!rsp_valid) else begin
            $display("an extra response arrived after the last expected one");
            error_count++;
        end
        $display("summary: %0d tests, %0d responses checked, %0d errors",
                 n_tests, n_done, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        int limit_ns;
        wait (trace_ready);
        limit_ns = trace.size() * cycles_per_txn * clk_period + reset_cycles * clk_period;
        #(limit_ns);
        $display("timeout after %0d ns with responses still missing", limit_ns);
        $display("Test failed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
source/ecc_code_pkg.sv
source/ecc_txn_pkg.sv
source/ecc_word_ram.sv
source/ecc_secded_lane.sv
source/ecc_req_stage.sv
source/ecc_rsp_merge.sv
source/ecc_mem_top.sv
test/ecc_tb.sv

// File: run.sh
#!/bin/sh
# builds the ECC memory testbench with Verilator and runs it from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f verilog.f \
    --top-module ecc_tb \
    -Mdir obj_dir -o ecc_sim

output=$(./obj_dir/ecc_sim)
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

// File: test/ecc_trace.txt
# id opcode(0 write, 1 read, 2 raw read) addr data inject exp_data sbit dbit
# id and opcode are decimal, all other columns hex; inject uses the stored 220-bit layout.
1 0 0 0123456789abcdef0123456789abcdef0123456789abcdef 0 0 0 0
1 0 5 fedcba9876543210fedcba9876543210fedcba9876543210 0 0 0 0
1 0 a a5a5a5a5a5a55a5a5a5a5a5affffffffffff000000000000 0 0 0 0
1 0 f 111111111111222222222222333333333333444444444444 0 0 0 0
1 1 0 0 0 0123456789abcdef0123456789abcdef0123456789abcdef 0 0
1 1 5 0 0 fedcba9876543210fedcba9876543210fedcba9876543210 0 0
1 1 a 0 0 a5a5a5a5a5a55a5a5a5a5a5affffffffffff000000000000 0 0
1 1 f 0 0 111111111111222222222222333333333333444444444444 0 0
2 0 1 0123456789abcdef0123456789abcdef0123456789abcdef 80 0 0 0
2 0 2 fedcba9876543210fedcba9876543210fedcba9876543210 10000000000000080 0 0 0
2 0 3 a5a5a5a5a5a55a5a5a5a5a5affffffffffff000000000000 10000000000000000000000000000000000000000000 0 0 0
2 1 1 0 0 0123456789abcdef0123456789abcdef0123456789abcdef 1 0
2 1 2 0 0 fedcba9876543210fedcba9876543210fedcba9876543210 3 0
2 1 3 0 0 a5a5a5a5a5a55a5a5a5a5a5affffffffffff000000000000 8 0
3 0 4 111111111111222222222222333333333333444444444444 400000000000000 0 0 0
3 0 6 0123456789abcdef0123456789abcdef0123456789abcdef 880 0 0 0
3 1 4 0 0 111111111111222222222222333333333333444444444444 2 0
3 1 6 0 0 0123456789abcdef0123456789abcdef0123456789abcdfe 0 1
4 2 6 0 0 0123456789abcdef0123456789abcdef0123456789abcdfe 0 0
4 2 1 0 0 0123456789abcdef0123456789abcdef0123456789abcdee 0 0
4 2 4 0 0 111111111111222222222222333333333333444444444444 0 0
5 0 7 fedcba9876543210fedcba9876543210fedcba9876543210 0 0 0 0
5 1 7 0 0 fedcba9876543210fedcba9876543210fedcba9876543210 0 0
5 0 7 a5a5a5a5a5a55a5a5a5a5a5affffffffffff000000000000 0 0 0 0
5 1 7 0 0 a5a5a5a5a5a55a5a5a5a5a5affffffffffff000000000000 0 0
5 0 8 111111111111222222222222333333333333444444444444 200000000000000000000000000000 0 0 0
5 1 8 0 0 111111111111222222222222333333333333444444444444 4 0
5 2 8 0 0 111111111111222222222223333333333333444444444444 0 0
5 0 9 0123456789abcdef0123456789abcdef0123456789abcdef 0 0 0 0
5 1 9 0 0 0123456789abcdef0123456789abcdef0123456789abcdef 0 0
5 1 0 0 0 0123456789abcdef0123456789abcdef0123456789abcdef 0 0
5 1 f 0 0 111111111111222222222222333333333333444444444444 0 0
